//--- src/mpdma_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mirror-padding DMA sizing macros
// Word and address widths, block sides, width field size
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MPDMA_DEFS_SVH
`define MPDMA_DEFS_SVH

// Bus widths
`define MPDMA_DATA_W     32
`define MPDMA_ADDR_W     32

// Core block and padded staging block side
`define MPDMA_BLK        4
`define MPDMA_PBLK       5

`define MPDMA_WIDTH_W    6     // Matrix side N, up to 60
`define MPDMA_WORD_BYTES 4

`endif

//--- src/mpdma_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the mirror-padding DMA engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mpdma_defs.svh"

package mpdma_pkg;

    typedef logic [`MPDMA_DATA_W-1:0]  data_t;
    typedef logic [`MPDMA_ADDR_W-1:0]  addr_t;    // Byte address
    typedef logic [`MPDMA_WIDTH_W-1:0] width_t;   // Matrix side N

    typedef logic [3:0] blk_idx_t;                // Block row or column
    typedef logic [2:0] buf_idx_t;                // Staging buffer coordinate 0..4

    // Which borders of the padded image this block touches
    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } edges_t;

endpackage

//--- src/mpdma_ifs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// blk_ctrl_if  block descriptor and phase handshakes
// pad_buf_if   staging buffer write and read ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface blk_ctrl_if import mpdma_pkg::*; ();
    blk_idx_t blk_x;
    blk_idx_t blk_y;
    edges_t   edges;
    addr_t    src_base;
    addr_t    dst_base;
    width_t   width;
    logic     rd_go;      // One-cycle phase starts
    logic     pad_go;
    logic     wr_go;
    logic     rd_done;    // One-cycle phase ends
    logic     wr_done;

    modport seq (output blk_x, blk_y, edges, src_base, dst_base, width,
                 output rd_go, pad_go, wr_go, input rd_done, wr_done);
    modport rd  (input blk_x, blk_y, edges, src_base, width, rd_go, output rd_done);
    modport pad (input edges, pad_go);
    modport wr  (input blk_x, blk_y, edges, dst_base, width, wr_go, output wr_done);
endinterface

interface pad_buf_if import mpdma_pkg::*; ();
    logic     we;
    buf_idx_t wx;
    buf_idx_t wy;
    data_t    wdata;
    buf_idx_t rx;
    buf_idx_t ry;
    data_t    rdata;      // Combinational read

    modport fill  (output we, wx, wy, wdata);
    modport store (input we, wx, wy, wdata, rx, ry, output rdata);
    modport drain (output rx, ry, input rdata);
endinterface

//--- src/block_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block sequencer: config capture, block grid walk,
// edge flags and read/pad/write phase chaining
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mpdma_defs.svh"

module block_sequencer import mpdma_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  addr_t  src_addr_i,
    input  addr_t  dst_addr_i,
    input  width_t mat_width_i,
    input  logic   start_i,
    output logic   done_o,
    blk_ctrl_if.seq ctrl
);

    addr_t    src_q, dst_q;
    width_t   width_q;
    blk_idx_t bx_q, by_q;
    blk_idx_t last_idx;
    logic     done_q;
    logic     rd_go_q, pad_go_q, wr_go_q;
    logic     width_ok, accept, last_blk;

    // Multiple of the block side, at least two blocks, at most 60
    assign width_ok = (mat_width_i % `MPDMA_BLK == 0) &&
                      (mat_width_i >= width_t'(2 * `MPDMA_BLK)) &&
                      (mat_width_i <= width_t'(60));
    assign accept   = start_i && done_q && width_ok;

    assign last_idx = blk_idx_t'(width_q / `MPDMA_BLK) - 4'd1;
    assign last_blk = (bx_q == last_idx) && (by_q == last_idx);

    // Configuration is held for the whole run
    always_ff @(posedge clk) begin
        if (accept) begin
            src_q   <= src_addr_i;
            dst_q   <= dst_addr_i;
            width_q <= mat_width_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q   <= 1'b1;
            bx_q     <= '0;
            by_q     <= '0;
            rd_go_q  <= 1'b0;
            pad_go_q <= 1'b0;
            wr_go_q  <= 1'b0;
        end else begin
            rd_go_q  <= 1'b0;
            pad_go_q <= ctrl.rd_done;    // Pad right after the fourth row lands
            wr_go_q  <= pad_go_q;        // Buffer is complete one cycle later
            if (accept) begin
                done_q  <= 1'b0;
                bx_q    <= '0;
                by_q    <= '0;
                rd_go_q <= 1'b1;
            end else if (ctrl.wr_done) begin
                if (last_blk) begin
                    done_q <= 1'b1;
                end else begin
                    rd_go_q <= 1'b1;
                    if (bx_q == last_idx) begin   // Row-major walk
                        bx_q <= '0;
                        by_q <= by_q + 4'd1;
                    end else begin
                        bx_q <= bx_q + 4'd1;
                    end
                end
            end
        end
    end

    assign ctrl.blk_x        = bx_q;
    assign ctrl.blk_y        = by_q;
    assign ctrl.src_base     = src_q;
    assign ctrl.dst_base     = dst_q;
    assign ctrl.width        = width_q;
    assign ctrl.edges.top    = (by_q == '0);
    assign ctrl.edges.bottom = (by_q == last_idx);
    assign ctrl.edges.left   = (bx_q == '0);
    assign ctrl.edges.right  = (bx_q == last_idx);
    assign ctrl.rd_go        = rd_go_q;
    assign ctrl.pad_go       = pad_go_q;
    assign ctrl.wr_go        = wr_go_q;
    assign done_o            = done_q;

endmodule

//--- src/block_reader.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI read master: four 4-beat row bursts per block,
// beats placed into the staging buffer core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mpdma_defs.svh"

module block_reader import mpdma_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    blk_ctrl_if.rd ctrl,
    pad_buf_if.fill fill,
    output addr_t  araddr_o,
    output logic   arvalid_o,
    input  logic   arready_i,
    input  data_t  rdata_i,
    input  logic   rlast_i,
    input  logic   rvalid_i,
    output logic   rready_o
);

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

    rd_state_e  state_q;
    logic [1:0] row_q, beat_q;
    logic       r_hs, row_end;

    assign r_hs    = rvalid_i && rready_o;
    assign row_end = r_hs && rlast_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= RD_IDLE;
            row_q   <= '0;
            beat_q  <= '0;
        end else begin
            case (state_q)
                RD_IDLE: if (ctrl.rd_go) begin
                    row_q   <= '0;
                    beat_q  <= '0;
                    state_q <= RD_ADDR;
                end
                RD_ADDR: if (arvalid_o && arready_i) state_q <= RD_DATA;
                RD_DATA: begin
                    if (r_hs) beat_q <= beat_q + 2'd1;
                    if (row_end) begin
                        beat_q <= '0;
                        if (row_q == 2'(`MPDMA_BLK - 1)) begin
                            state_q <= RD_IDLE;
                        end else begin
                            row_q   <= row_q + 2'd1;
                            state_q <= RD_ADDR;
                        end
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // Core row k starts at src + ((by*4 + k)*N + bx*4) words
    assign araddr_o  = ctrl.src_base +
                       ((addr_t'(ctrl.blk_y) * `MPDMA_BLK + addr_t'(row_q)) * addr_t'(ctrl.width) +
                        addr_t'(ctrl.blk_x) * `MPDMA_BLK) * `MPDMA_WORD_BYTES;
    assign arvalid_o = (state_q == RD_ADDR);
    assign rready_o  = (state_q == RD_DATA);

    assign ctrl.rd_done = row_end && (row_q == 2'(`MPDMA_BLK - 1));

    // Core shifts by one only past a leading pad
    assign fill.we    = r_hs;
    assign fill.wx    = buf_idx_t'(beat_q) + buf_idx_t'(ctrl.edges.left);
    assign fill.wy    = buf_idx_t'(row_q) + buf_idx_t'(ctrl.edges.top);
    assign fill.wdata = rdata_i;

endmodule

//--- src/pad_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 5x5 staging buffer with single-cycle mirror fill
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mpdma_defs.svh"

module pad_buffer import mpdma_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    blk_ctrl_if.pad ctrl,
    pad_buf_if.store store
);

    localparam int MID = `MPDMA_PBLK / 2;   // Mirror source index for every pad

    data_t mem [0:`MPDMA_PBLK-1][0:`MPDMA_PBLK-1];   // [y][x]

    logic [`MPDMA_PBLK-1:0] pad_row;
    logic [`MPDMA_PBLK-1:0] pad_col;

    // Pads only ever sit at index 0 or 4
    always_comb begin
        pad_row                 = '0;
        pad_col                 = '0;
        pad_row[0]              = ctrl.edges.top;
        pad_row[`MPDMA_PBLK-1]  = ctrl.edges.bottom;
        pad_col[0]              = ctrl.edges.left;
        pad_col[`MPDMA_PBLK-1]  = ctrl.edges.right;
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            if (store.we) mem[store.wy][store.wx] <= store.wdata;

            // Pad row takes core row at MID, pad column takes column MID,
            // and a corner takes the diagonal inner cell (MID, MID)
            if (ctrl.pad_go) begin
                for (int y = 0; y < `MPDMA_PBLK; y++) begin
                    for (int x = 0; x < `MPDMA_PBLK; x++) begin
                        if (pad_row[y] || pad_col[x]) begin
                            mem[y][x] <= mem[pad_row[y] ? MID : y][pad_col[x] ? MID : x];
                        end
                    end
                end
            end
        end
    end

    assign store.rdata = mem[store.ry][store.rx];

endmodule

//--- src/row_writer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI write master: one INCR burst per padded block row,
// AW, W and B phases sequenced row by row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mpdma_defs.svh"

module row_writer import mpdma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    blk_ctrl_if.wr     ctrl,
    pad_buf_if.drain   drain,
    output addr_t      awaddr_o,
    output logic [3:0] awlen_o,
    output logic       awvalid_o,
    input  logic       awready_i,
    output data_t      wdata_o,
    output logic       wlast_o,
    output logic       wvalid_o,
    input  logic       wready_i,
    input  logic       bvalid_i,
    output logic       bready_o
);

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

    wr_state_e state_q;
    buf_idx_t  row_q, beat_q;
    buf_idx_t  n_rows, row_len;
    logic      last_beat, last_row;
    logic      w_hs, b_hs, row_done;

    // 4 core rows/columns plus one per pad present
    assign n_rows  = buf_idx_t'(`MPDMA_BLK) + buf_idx_t'(ctrl.edges.top)
                   + buf_idx_t'(ctrl.edges.bottom);
    assign row_len = buf_idx_t'(`MPDMA_BLK) + buf_idx_t'(ctrl.edges.left)
                   + buf_idx_t'(ctrl.edges.right);

    assign last_beat = (beat_q == row_len - 3'd1);
    assign last_row  = (row_q == n_rows - 3'd1);
    assign w_hs      = wvalid_o && wready_i;
    assign b_hs      = bvalid_i && bready_o;
    assign row_done  = b_hs && ((state_q == WR_RESP) || w_hs);   // B may meet wlast

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= WR_IDLE;
            row_q   <= '0;
            beat_q  <= '0;
        end else begin
            case (state_q)
                WR_IDLE: if (ctrl.wr_go) begin
                    row_q   <= '0;
                    beat_q  <= '0;
                    state_q <= WR_ADDR;
                end
                WR_ADDR: if (awvalid_o && awready_i) state_q <= WR_DATA;
                WR_DATA: if (w_hs) begin
                    if (last_beat) begin
                        beat_q  <= '0;
                        state_q <= WR_RESP;
                    end else begin
                        beat_q <= beat_q + 3'd1;
                    end
                end
                default: ;
            endcase
            // Row closes on its B handshake, overriding the moves above
            if (row_done) begin
                if (last_row) begin
                    state_q <= WR_IDLE;
                end else begin
                    row_q   <= row_q + 3'd1;
                    state_q <= WR_ADDR;
                end
            end
        end
    end

    // Row r lands at dst + ((by*4 + r + !top)*(N+2) + bx*4 + !left) words
    assign awaddr_o  = ctrl.dst_base +
                       ((addr_t'(ctrl.blk_y) * `MPDMA_BLK + addr_t'(row_q) +
                         addr_t'(!ctrl.edges.top)) * (addr_t'(ctrl.width) + 2) +
                        addr_t'(ctrl.blk_x) * `MPDMA_BLK + addr_t'(!ctrl.edges.left)) *
                       `MPDMA_WORD_BYTES;
    assign awlen_o   = 4'(row_len) - 4'd1;
    assign awvalid_o = (state_q == WR_ADDR);

    assign drain.rx  = beat_q;      // Window always starts at buffer (0,0)
    assign drain.ry  = row_q;
    assign wdata_o   = drain.rdata;
    assign wvalid_o  = (state_q == WR_DATA);
    assign wlast_o   = (state_q == WR_DATA) && last_beat;
    assign bready_o  = wlast_o || (state_q == WR_RESP);

    assign ctrl.wr_done = row_done && last_row;

endmodule

//--- src/mpdma_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mirror-padding DMA engine top level
// Config port plus AXI read and write master ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module mpdma_top import mpdma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // Configuration
    input  addr_t      src_addr_i,
    input  addr_t      dst_addr_i,
    input  width_t     mat_width_i,
    input  logic       start_i,
    output logic       done_o,

    // AXI read
    output addr_t      araddr_o,
    output logic       arvalid_o,
    input  logic       arready_i,
    input  data_t      rdata_i,
    input  logic       rlast_i,
    input  logic       rvalid_i,
    output logic       rready_o,

    // AXI write
    output addr_t      awaddr_o,
    output logic [3:0] awlen_o,
    output logic       awvalid_o,
    input  logic       awready_i,
    output data_t      wdata_o,
    output logic       wlast_o,
    output logic       wvalid_o,
    input  logic       wready_i,
    input  logic       bvalid_i,
    output logic       bready_o
);

    blk_ctrl_if u_ctrl ();
    pad_buf_if  u_buf ();

    block_sequencer u_seq (
        .clk, .rst_n, .src_addr_i, .dst_addr_i, .mat_width_i, .start_i, .done_o,
        .ctrl (u_ctrl.seq)
    );

    block_reader u_rd (
        .clk, .rst_n, .ctrl (u_ctrl.rd), .fill (u_buf.fill),
        .araddr_o, .arvalid_o, .arready_i, .rdata_i, .rlast_i, .rvalid_i, .rready_o
    );

    pad_buffer u_pad (
        .clk, .rst_n, .ctrl (u_ctrl.pad), .store (u_buf.store)
    );

    row_writer u_wr (
        .clk, .rst_n, .ctrl (u_ctrl.wr), .drain (u_buf.drain),
        .awaddr_o, .awlen_o, .awvalid_o, .awready_i,
        .wdata_o, .wlast_o, .wvalid_o, .wready_i, .bvalid_i, .bready_o
    );

endmodule

//--- tb/axi_mem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI slave memory, 4096 words, with LFSR-random ready and
// valid delays, a word load port and a burst length flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axi_mem_model import mpdma_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load_en_i,
    input  logic [11:0] load_addr_i,
    input  data_t       load_data_i,
    input  addr_t       araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output data_t       rdata_o,
    output logic        rlast_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    input  addr_t       awaddr_i,
    input  logic [3:0]  awlen_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  data_t       wdata_i,
    input  logic        wlast_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic        bvalid_o,
    input  logic        bready_i,
    output logic        burst_err_o
);

    data_t       mem [0:4095];
    logic [31:0] lfsr_q;
    logic        rd_busy, wr_busy, b_pend;
    logic [11:0] rd_ptr, wr_ptr;   // Word pointers
    logic [1:0]  rd_beat;
    logic [3:0]  wr_len, wr_beat;

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    always @(posedge clk) begin
        logic [31:0] s;
        logic [4:0]  bits;    // ar, r, aw, w, b
        s = lfsr_q;
        for (int i = 0; i < 5; i++) begin
            bits[i] = s[0];
            s = lfsr_next(s);
        end
        if (!rst_n) begin
            lfsr_q      <= 32'hbc8c_bad6;
            arready_o   <= 1'b0;
            rvalid_o    <= 1'b0;
            rlast_o     <= 1'b0;
            rdata_o     <= '0;
            awready_o   <= 1'b0;
            wready_o    <= 1'b0;
            bvalid_o    <= 1'b0;
            burst_err_o <= 1'b0;
            rd_busy     <= 1'b0;
            wr_busy     <= 1'b0;
            b_pend      <= 1'b0;
            rd_beat     <= '0;
            wr_beat     <= '0;
        end else begin
            lfsr_q <= s;
            if (load_en_i) mem[load_addr_i] <= load_data_i;

            // Read side, one 4-beat burst at a time
            if (arvalid_i && arready_o) begin
                rd_busy <= 1'b1;
                rd_ptr  <= araddr_i[13:2];
                rd_beat <= '0;
            end
            arready_o <= bits[0] && !rd_busy && !(arvalid_i && arready_o);
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
                rd_ptr   <= rd_ptr + 12'd1;
                rd_beat  <= rd_beat + 2'd1;
                if (rlast_o) rd_busy <= 1'b0;
            end else if (rd_busy && !rvalid_o && bits[1]) begin
                rvalid_o <= 1'b1;
                rdata_o  <= mem[rd_ptr];
                rlast_o  <= (rd_beat == 2'd3);
            end

            // Write side, B only after the last W beat
            if (awvalid_i && awready_o) begin
                wr_busy <= 1'b1;
                wr_ptr  <= awaddr_i[13:2];
                wr_len  <= awlen_i;
                wr_beat <= '0;
            end
            awready_o <= bits[2] && !wr_busy && !(awvalid_i && awready_o);
            if (wvalid_i && wready_o) begin
                mem[wr_ptr] <= wdata_i;
                wr_ptr      <= wr_ptr + 12'd1;
                wr_beat     <= wr_beat + 4'd1;
                if (wlast_i != (wr_beat == wr_len)) burst_err_o <= 1'b1;   // Sticky
                if (wlast_i) b_pend <= 1'b1;
            end
            wready_o <= bits[3] && wr_busy && !b_pend && !(wvalid_i && wready_o && wlast_i);
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
                b_pend   <= 1'b0;
                wr_busy  <= 1'b0;
            end else if (b_pend && !bvalid_o && bits[4]) begin
                bvalid_o <= 1'b1;
            end
        end
    end

endmodule

//--- tb/tb_mpdma.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the mirror-padding DMA engine: test table,
// reference padding model, compare tasks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mpdma_defs.svh"

module tb_mpdma import mpdma_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int MEM_WORDS  = 4096;
    localparam int NUM_TESTS  = 7;
    localparam int BEAT_BOUND = 40;    // Worst-case cycles per padded word

    typedef struct packed {
        addr_t  src;
        addr_t  dst;
        width_t width;
        logic   valid;     // Expected to start a run
    } test_entry_t;

    test_entry_t tests [0:NUM_TESTS-1] = '{
        '{32'h0000_0100, 32'h0000_1000, 6'd8,  1'b1},
        '{32'h0000_0100, 32'h0000_1000, 6'd0,  1'b0},
        '{32'h0000_0400, 32'h0000_2000, 6'd12, 1'b1},
        '{32'h0000_0400, 32'h0000_2000, 6'd6,  1'b0},
        '{32'h0000_0800, 32'h0000_3000, 6'd16, 1'b1},
        '{32'h0000_0800, 32'h0000_3000, 6'd4,  1'b0},
        '{32'h0000_0c40, 32'h0000_3800, 6'd8,  1'b1}   // Unaligned source base
    };

    logic        clk, rst_n;
    addr_t       src_addr, dst_addr;
    width_t      mat_width;
    logic        start, done;
    addr_t       araddr, awaddr;
    logic        arvalid, arready, rlast, rvalid, rready;
    data_t       rdata, wdata;
    logic [3:0]  awlen;
    logic        awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic        load_en, burst_err;
    logic [11:0] load_addr;
    data_t       load_data;

    mpdma_top u_dut (
        .clk, .rst_n,
        .src_addr_i (src_addr), .dst_addr_i (dst_addr), .mat_width_i (mat_width),
        .start_i (start), .done_o (done),
        .araddr_o (araddr), .arvalid_o (arvalid), .arready_i (arready),
        .rdata_i (rdata), .rlast_i (rlast), .rvalid_i (rvalid), .rready_o (rready),
        .awaddr_o (awaddr), .awlen_o (awlen), .awvalid_o (awvalid), .awready_i (awready),
        .wdata_o (wdata), .wlast_o (wlast), .wvalid_o (wvalid), .wready_i (wready),
        .bvalid_i (bvalid), .bready_o (bready)
    );

    axi_mem_model u_mem (
        .clk, .rst_n,
        .load_en_i (load_en), .load_addr_i (load_addr), .load_data_i (load_data),
        .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rlast_o (rlast), .rvalid_o (rvalid), .rready_i (rready),
        .awaddr_i (awaddr), .awlen_i (awlen), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wlast_i (wlast), .wvalid_i (wvalid), .wready_o (wready),
        .bvalid_o (bvalid), .bready_i (bready), .burst_err_o (burst_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Odd multiplier keeps every word address distinct
    function automatic data_t pattern_word(input int idx);
        return (32'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    // Padded index -1 maps to 1, index N maps to N-2
    function automatic int mirror_index(input int i, input int n);
        if (i < 0) return 1;
        if (i >= n) return n - 2;
        return i;
    endfunction

    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_word(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("Error %0t ns: %s, got %08h, expected %08h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= 12'(i);
            load_data <= pattern_word(i);
            @(negedge clk);
            check_flag(done, 1'b1, "done_o high while idle");
            check_flag(arvalid || awvalid, 1'b0, "no AR or AW request while idle");
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic check_image(input test_entry_t t);
        int n, sw, dw, sr, sc;
        n  = int'(t.width);
        sw = int'(t.src >> 2);
        dw = int'(t.dst >> 2);
        for (int pr = 0; pr < n + 2; pr++) begin
            for (int pc = 0; pc < n + 2; pc++) begin
                sr = mirror_index(pr - 1, n);
                sc = mirror_index(pc - 1, n);
                check_word(u_mem.mem[12'(dw + pr * (n + 2) + pc)], pattern_word(sw + sr * n + sc),
                           $sformatf("padded word (%0d,%0d) for N=%0d", pr, pc, n));
            end
        end
        check_word(u_mem.mem[12'(dw - 1)], pattern_word(dw - 1), "guard word before destination");
        check_word(u_mem.mem[12'(dw + (n + 2) * (n + 2))], pattern_word(dw + (n + 2) * (n + 2)),
                   "guard word after destination");
        for (int i = 0; i < n * n; i++) begin
            check_word(u_mem.mem[12'(sw + i)], pattern_word(sw + i), "source word unchanged");
        end
    endtask

    task automatic run_entry(input test_entry_t t);
        int n, b_cnt, w_cnt;
        n     = int'(t.width);
        b_cnt = 0;
        w_cnt = 0;
        @(posedge clk);
        src_addr  <= t.src;
        dst_addr  <= t.dst;
        mat_width <= t.width;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (t.valid) begin
            check_flag(done, 1'b0, "done_o drops after a valid start");
            while (done !== 1'b1) begin
                if (bvalid && bready) b_cnt++;
                if (wvalid && wready) w_cnt++;
                @(negedge clk);
            end
            // One B per padded block row, one W beat per padded word
            check_word(data_t'(b_cnt), data_t'((n / 4) * (n + 2)), "B responses before done_o");
            check_word(data_t'(w_cnt), data_t'((n + 2) * (n + 2)), "W beats before done_o");
            check_flag(burst_err, 1'b0, "W burst length matches awlen");
            check_image(t);
        end else begin
            repeat (20) begin
                check_flag(done, 1'b1, "done_o stays high for an invalid width");
                check_flag(arvalid, 1'b0, "no read request for an invalid width");
                @(negedge clk);
            end
        end
    endtask

    initial begin
        rst_n     <= 1'b0;
        start     <= 1'b0;
        src_addr  <= '0;
        dst_addr  <= '0;
        mat_width <= '0;
        load_en   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        fill_memory();
        foreach (tests[i]) begin
            run_entry(tests[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

    initial begin : watchdog
        longint limit, side;
        limit = 2 * MEM_WORDS + 100;    // Reset and memory fill
        foreach (tests[i]) begin
            side = longint'(tests[i].width) + 2;
            limit += tests[i].valid ? side * side * BEAT_BOUND : 40;
        end
        #(limit * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verilog.f
+incdir+src
src/mpdma_pkg.sv
src/mpdma_ifs.sv
src/block_sequencer.sv
src/block_reader.sv
src/pad_buffer.sv
src/row_writer.sv
src/mpdma_top.sv
tb/axi_mem_model.sv
tb/tb_mpdma.sv

//--- Makefile
TOP := tb_mpdma

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "^=== PASS ===$$"

clean:
	rm -rf obj_dir
